// ==== files.f ====
hw/bpu_pkg.sv
hw/bpu_btb.sv
hw/bpu_bht.sv
hw/bpu_ras.sv
hw/bpu_predict.sv
hw/bpf.sv
hw/bpu_top.sv
verification/tb_clkgen.sv
verification/tb_bpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the branch prediction unit testbench with Verilator, run it, scan the log
verilator --binary --timing --top-module tb_bpu_top -f files.f -o sim_bpu > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_bpu > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== verification/tb_bpu_top.sv ====
// Testbench for the branch prediction unit, random and directed branches against a model
`timescale 1ns/1ps

module tb_bpu_top;
	import bpu_pkg::*;

	localparam int N_IDLE    = 8;
	localparam int N_COND    = 400;
	localparam int N_MIX     = 560;
	localparam int POOL_SIZE = 8;
	// Roughly 1000 test cycles plus margin
	localparam int TIMEOUT_CYCLES = 1200;

	logic         clk;
	logic         rst_n;
	logic         fetch_valid;
	logic         fetch_stall;
	logic [31:2]  fetch_pc;
	logic         res_valid;
	logic         res_stall;
	logic [31:0]  res_pc;
	branch_inst_u res_inst;
	branch_type_t res_type;
	cmp_type_t    res_cmp;
	logic         res_link;
	logic [31:0]  res_rj;
	logic [31:0]  res_rd;
	logic [31:2]  res_pred_npc;
	logic         csr_flush;
	logic [31:0]  csr_target;
	logic         pred_valid;
	logic [31:2]  pred_npc;
	logic         pred_taken;
	logic         redirect;
	logic [31:2]  redirect_pc;
	logic [31:0]  link;

	// Reference tables
	logic         m_btb_valid [BTB_DEPTH];
	logic [31:2]  m_btb_pc [BTB_DEPTH];
	logic [31:2]  m_btb_target [BTB_DEPTH];
	br_kind_t     m_btb_kind [BTB_DEPTH];
	int           m_bht [BHT_DEPTH];
	logic [31:2]  m_ras [$];

	logic         exp_pv;
	logic         exp_pt;
	logic [31:2]  exp_pnpc;
	logic         exp_redir;
	logic [31:2]  exp_rpc;
	logic [31:0]  exp_link;
	logic [31:0]  pc_pool [POOL_SIZE];
	integer       seed;
	int           npc_errs;
	int           redirect_errs;
	int           link_errs;
	int           total_errs;
	int           cycle_cnt = 0;

	tb_clkgen u_clkgen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	bpu_top u_dut (
		.clk               (clk),
		.rst_n_i           (rst_n),
		.fetch_valid_i     (fetch_valid),
		.fetch_stall_i     (fetch_stall),
		.fetch_pc_i        (fetch_pc),
		.pred_valid_o      (pred_valid),
		.pred_npc_o        (pred_npc),
		.pred_taken_o      (pred_taken),
		.res_valid_i       (res_valid),
		.res_stall_i       (res_stall),
		.res_pc_i          (res_pc),
		.res_inst_i        (res_inst),
		.res_branch_type_i (res_type),
		.res_cmp_type_i    (res_cmp),
		.res_link_i        (res_link),
		.res_rj_i          (res_rj),
		.res_rd_i          (res_rd),
		.res_pred_npc_i    (res_pred_npc),
		.csr_flush_i       (csr_flush),
		.csr_target_i      (csr_target),
		.redirect_o        (redirect),
		.redirect_pc_o     (redirect_pc),
		.link_o            (link)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout, the test sequence did not finish within %0d cycles",
			         TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [31:0] model_target(input branch_type_t ty, input logic [31:0] pc,
	                                             input branch_inst_u inst, input logic [31:0] rj);
		logic [31:0] off26;
		logic [31:0] off16;
		off26 = 32'($signed(inst.offs26)) << 2;
		off16 = 32'($signed(inst.reg_form.offs16)) << 2;
		case (ty)
			IMMEDIATE: return pc + off26;
			INDIRECT:  return rj + off16;
			CONDITION: return pc + off16;
			default:   return pc + 32'd4;
		endcase
	endfunction

	function automatic logic model_taken(input branch_type_t ty, input cmp_type_t cmp,
	                                     input logic [31:0] a, input logic [31:0] b);
		int sa;
		int sb;
		sa = a;
		sb = b;
		if (ty == INVALID) return 1'b0;
		if (ty != CONDITION) return 1'b1;
		case (cmp)
			EQL:     return a == b;
			NEQ:     return a != b;
			LSS:     return sa < sb;
			GER:     return sa > sb;
			LEQ:     return sa <= sb;
			GEQ:     return sa >= sb;
			LTU:     return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic br_kind_t model_kind(input branch_type_t ty, input branch_inst_u inst,
	                                        input logic lnk);
		if (lnk || (ty == INDIRECT && inst.reg_form.rd == 5'd1)) return CALL;
		if (ty == INDIRECT && inst.reg_form.rj == 5'd1 && inst.reg_form.offs16 == 16'd0)
			return RETURN;
		if (ty == IMMEDIATE || ty == INDIRECT) return ABSOLUTE;
		return PC_RELATIVE;
	endfunction

	task automatic model_predict(input logic [31:2] pc, output logic taken,
	                             output logic [31:2] npc);
		int   idx;
		logic hit;
		idx   = int'(pc[2 +: BTB_IDX_W]);
		hit   = m_btb_valid[idx] && (m_btb_pc[idx] == pc);
		taken = 1'b0;
		npc   = pc + 30'd1;
		if (hit && m_btb_kind[idx] == RETURN && m_ras.size() > 0) begin
			taken = 1'b1;
			npc   = m_ras[$];
		end else if (hit && (m_btb_kind[idx] == CALL || m_btb_kind[idx] == ABSOLUTE ||
		                     m_bht[int'(pc[2 +: BHT_IDX_W])] >= 2)) begin
			taken = 1'b1;
			npc   = m_btb_target[idx];
		end
	endtask

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_npc(input string name, input logic exp_valid, input logic exp_taken,
	                         input logic [31:2] exp_npc, input logic act_valid,
	                         input logic act_taken, input logic [31:2] act_npc);
		if (act_valid !== exp_valid ||
		    (exp_valid && (act_taken !== exp_taken || act_npc !== exp_npc))) begin
			npc_errs++;
			$display("FAIL %s prediction expected valid %0b taken %0b npc %h actual %0b %0b %h",
			         name, exp_valid, exp_taken, exp_npc, act_valid, act_taken, act_npc);
		end
	endtask

	task automatic check_redirect(input string name, input logic exp_redir,
	                              input logic [31:2] exp_pc, input logic act_redir,
	                              input logic [31:2] act_pc);
		if (act_redir !== exp_redir || (exp_redir && act_pc !== exp_pc)) begin
			redirect_errs++;
			$display("FAIL %s redirect expected %0b pc %h actual %0b pc %h",
			         name, exp_redir, exp_pc, act_redir, act_pc);
		end
	endtask

	task automatic check_link(input string name, input logic [31:0] exp_val,
	                          input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			link_errs++;
			$display("FAIL %s link expected %h actual %h", name, exp_val, act_val);
		end
	endtask

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	function automatic branch_inst_u long_inst(input logic [25:0] offs26);
		branch_inst_u inst;
		inst.offs26 = offs26;
		return inst;
	endfunction

	function automatic branch_inst_u reg_inst(input logic [15:0] offs16, input logic [4:0] rj,
	                                          input logic [4:0] rd);
		branch_inst_u inst;
		inst.reg_form.offs16 = offs16;
		inst.reg_form.rj     = rj;
		inst.reg_form.rd     = rd;
		return inst;
	endfunction

	task automatic set_fetch(input logic valid, input logic [31:0] pc);
		fetch_valid = valid;
		fetch_stall = 1'b0;
		fetch_pc    = pc[31:2];
	endtask

	task automatic random_fetch();
		fetch_valid = (rand_below(8) != 0);
		fetch_stall = (rand_below(8) == 0);
		fetch_pc    = pc_pool[rand_below(POOL_SIZE)][31:2];
	endtask

	task automatic idle_resolve();
		res_valid = 1'b0;
		res_stall = 1'b0;
		res_type  = INVALID;
		res_link  = 1'b0;
		csr_flush = 1'b0;
	endtask

	// Predicted not taken unless the caller changes it
	task automatic set_branch(input branch_type_t ty, input logic [31:0] pc,
	                          input branch_inst_u inst, input logic lnk,
	                          input logic [31:0] rj, input logic [31:0] rd);
		res_valid    = 1'b1;
		res_stall    = 1'b0;
		csr_flush    = 1'b0;
		res_type     = ty;
		res_pc       = pc;
		res_inst     = inst;
		res_cmp      = EQL;
		res_link     = lnk;
		res_rj       = rj;
		res_rd       = rd;
		res_pred_npc = pc[31:2] + 30'd1;
	endtask

	task automatic random_branch(input branch_type_t ty);
		branch_inst_u inst;
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  tgt;
		inst.offs26 = 26'($random(seed));
		a = $random(seed);
		case (rand_below(4))
			0:       b = a;
			1:       b = a ^ 32'h8000_0000;
			2:       b = a + 32'd1;
			default: b = $random(seed);
		endcase
		// Some jirl become calls or returns
		if (ty == INDIRECT) begin
			case (rand_below(4))
				0: inst.reg_form.rd = 5'd1;
				1: begin
					inst = reg_inst(16'd0, 5'd1, 5'd0);
					a    = pc_pool[rand_below(POOL_SIZE)] + 32'd4;
				end
				default: ;
			endcase
		end
		set_branch(ty, pc_pool[rand_below(POOL_SIZE)], inst,
		           ty == IMMEDIATE && rand_below(4) == 0, a, b);
		res_cmp = cmp_type_t'(3'(rand_below(8)));
		tgt     = model_target(ty, res_pc, inst, a);
		case (rand_below(3))
			0:       res_pred_npc = res_pc[31:2] + 30'd1;
			1:       res_pred_npc = tgt[31:2];
			default: res_pred_npc = 30'($random(seed));
		endcase
	endtask

	// One clock with expectations taken from the model before the edge
	task automatic step_cycle(input string name);
		logic [31:0] tgt;
		logic        tkn;
		br_kind_t    knd;
		logic [31:0] real_npc;
		logic        fire;
		logic        p_taken;
		logic [31:2] p_npc;
		int          cnt_idx;
		int          btb_idx;
		if (!fetch_stall) begin
			model_predict(fetch_pc, p_taken, p_npc);
			exp_pv   = fetch_valid;
			exp_pt   = p_taken;
			exp_pnpc = p_npc;
		end
		tgt       = model_target(res_type, res_pc, res_inst, res_rj);
		tkn       = model_taken(res_type, res_cmp, res_rj, res_rd);
		knd       = model_kind(res_type, res_inst, res_link);
		real_npc  = tkn ? tgt : res_pc + 32'd4;
		fire      = res_valid && !res_stall;
		exp_redir = (fire && real_npc[31:2] != res_pred_npc) || csr_flush;
		exp_rpc   = csr_flush ? csr_target[31:2] : real_npc[31:2];
		exp_link  = res_pc + 32'd4;
		cnt_idx   = int'(res_pc[2 +: BHT_IDX_W]);
		btb_idx   = int'(res_pc[2 +: BTB_IDX_W]);
		@(posedge clk);
		if (fire && res_type != INVALID) begin
			if (tkn && m_bht[cnt_idx] < 3) begin
				m_bht[cnt_idx]++;
			end else if (!tkn && m_bht[cnt_idx] > 0) begin
				m_bht[cnt_idx]--;
			end
			if (knd == CALL) begin
				m_ras.push_back(exp_link[31:2]);
				// Oldest return address falls off a full stack
				if (m_ras.size() > RAS_DEPTH) void'(m_ras.pop_front());
			end else if (knd == RETURN && m_ras.size() > 0) begin
				void'(m_ras.pop_back());
			end
		end
		if (fire && tkn) begin
			m_btb_valid[btb_idx]  = 1'b1;
			m_btb_pc[btb_idx]     = res_pc[31:2];
			m_btb_target[btb_idx] = tgt[31:2];
			m_btb_kind[btb_idx]   = knd;
		end
		#1;
		check_npc(name, exp_pv, exp_pt, exp_pnpc, pred_valid, pred_taken, pred_npc);
		check_redirect(name, exp_redir, exp_rpc, redirect, redirect_pc);
		check_link(name, exp_link, link);
	endtask

	task automatic run_directed();
		// Taken b, then a fetch of the same PC
		set_fetch(1'b0, pc_pool[0]);
		set_branch(IMMEDIATE, pc_pool[1], long_inst(26'h40), 1'b0, 32'd0, 32'd0);
		step_cycle("imm_resolve");
		idle_resolve();
		set_fetch(1'b1, pc_pool[1]);
		step_cycle("imm_predict");
		// Counter goes 0, 1, 2 and only the last fetch predicts taken
		for (int i = 0; i < 3; i++) begin
			set_fetch(1'b0, pc_pool[0]);
			set_branch(CONDITION, pc_pool[2], reg_inst(16'h0010, 5'd4, 5'd5), 1'b0,
			           32'd7, (i == 0) ? 32'd9 : 32'd7);
			step_cycle("cond_train");
			idle_resolve();
			set_fetch(1'b1, pc_pool[2]);
			step_cycle("cond_predict");
		end
		// Return entry first, then bl and jirl calls feed the stack
		set_fetch(1'b0, pc_pool[0]);
		set_branch(INDIRECT, pc_pool[6], reg_inst(16'd0, 5'd1, 5'd0), 1'b0, 32'h1c00_0a00, 32'd0);
		step_cycle("ret_train");
		set_branch(IMMEDIATE, pc_pool[3], long_inst(26'h80), 1'b1, 32'd0, 32'd0);
		step_cycle("bl_call");
		idle_resolve();
		set_fetch(1'b1, pc_pool[6]);
		step_cycle("ret_predict_bl");
		set_fetch(1'b0, pc_pool[0]);
		set_branch(INDIRECT, pc_pool[7], reg_inst(16'h0008, 5'd5, 5'd1), 1'b0, 32'h1c00_0800, 32'd0);
		step_cycle("jirl_call");
		idle_resolve();
		set_fetch(1'b1, pc_pool[6]);
		step_cycle("ret_predict_jirl");
		set_branch(INDIRECT, pc_pool[6], reg_inst(16'd0, 5'd1, 5'd0), 1'b0,
		           pc_pool[7] + 32'd4, 32'd0);
		res_pred_npc = pc_pool[7][31:2] + 30'd1;
		step_cycle("ret_resolve");
		idle_resolve();
		step_cycle("ret_predict_after_pop");
		// Stalled wrong prediction, then CSR flushes
		set_fetch(1'b0, pc_pool[0]);
		set_branch(IMMEDIATE, pc_pool[0], long_inst(26'h3ff00), 1'b0, 32'd0, 32'd0);
		res_stall = 1'b1;
		step_cycle("stall_no_redirect");
		idle_resolve();
		set_fetch(1'b1, pc_pool[0]);
		step_cycle("stall_no_train");
		set_branch(IMMEDIATE, pc_pool[0], long_inst(26'h3ff00), 1'b0, 32'd0, 32'd0);
		res_stall  = 1'b1;
		csr_flush  = 1'b1;
		csr_target = 32'h1c00_8000;
		step_cycle("flush_under_stall");
		set_branch(CONDITION, pc_pool[4], reg_inst(16'h0020, 5'd4, 5'd5), 1'b0, 32'd3, 32'd4);
		csr_flush  = 1'b1;
		csr_target = 32'h1c00_9000;
		step_cycle("flush_correct_pred");
		idle_resolve();
	endtask

	initial begin
		seed          = 32'h724a;
		npc_errs      = 0;
		redirect_errs = 0;
		link_errs     = 0;
		exp_pv        = 1'b0;
		exp_pt        = 1'b0;
		exp_pnpc      = '0;
		// Pool with BTB and BHT index aliases
		pc_pool[0] = 32'h1c00_0100;
		pc_pool[1] = 32'h1c00_0104;
		pc_pool[2] = 32'h1c00_0110;
		pc_pool[3] = 32'h1c00_021c;
		pc_pool[4] = 32'h1c00_0140;
		pc_pool[5] = 32'h1c00_0180;
		pc_pool[6] = 32'h1c00_0328;
		pc_pool[7] = 32'h1c00_043c;
		for (int i = 0; i < BTB_DEPTH; i++) begin
			m_btb_valid[i]  = 1'b0;
			m_btb_pc[i]     = '0;
			m_btb_target[i] = '0;
			m_btb_kind[i]   = PC_RELATIVE;
		end
		for (int i = 0; i < BHT_DEPTH; i++) begin
			m_bht[i] = 1;
		end
		set_fetch(1'b0, 32'd0);
		set_branch(INVALID, 32'd0, long_inst(26'd0), 1'b0, 32'd0, 32'd0);
		idle_resolve();
		csr_target = 32'd0;
		wait (rst_n === 1'b1);

		for (int i = 0; i < N_IDLE; i++) begin
			set_fetch(1'b1, pc_pool[i]);
			step_cycle("reset_fetch");
		end
		run_directed();
		for (int i = 0; i < N_COND; i++) begin
			random_fetch();
			random_branch(CONDITION);
			step_cycle("cond_random");
		end
		for (int i = 0; i < N_MIX; i++) begin
			random_fetch();
			random_branch(branch_type_t'(2'(rand_below(4))));
			if (rand_below(8) == 0) res_valid = 1'b0;
			res_stall = (rand_below(8) == 0);
			if (rand_below(16) == 0) begin
				csr_flush  = 1'b1;
				csr_target = $random(seed);
			end
			step_cycle("mixed_random");
		end

		total_errs = npc_errs + redirect_errs + link_errs;
		$display("Error counts: prediction %0d, redirect %0d, link %0d",
		         npc_errs, redirect_errs, link_errs);
		if (total_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== verification/tb_clkgen.sv ====
// Testbench clock and reset source with an 8 ns period and reset held for 8 cycles
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);
	localparam int RESET_CYCLES = 8;

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		// Release just after the edge
		#1;
		rst_n_o = 1'b1;
	end

	always #4 clk_o = ~clk_o;

endmodule

// ==== hw/bpu_top.sv ====
// Branch prediction unit top joining fetch prediction, tables and resolve feedback
`timescale 1ns/1ps

module bpu_top (
	input  logic                  clk,
	input  logic                  rst_n_i,
	// Fetch side
	input  logic                  fetch_valid_i,
	input  logic                  fetch_stall_i,
	input  logic [31:2]           fetch_pc_i,
	output logic                  pred_valid_o,
	output logic [31:2]           pred_npc_o,
	output logic                  pred_taken_o,
	// Resolve side
	input  logic                  res_valid_i,
	input  logic                  res_stall_i,
	input  logic [31:0]           res_pc_i,
	input  bpu_pkg::branch_inst_u res_inst_i,
	input  bpu_pkg::branch_type_t res_branch_type_i,
	input  bpu_pkg::cmp_type_t    res_cmp_type_i,
	input  logic                  res_link_i,
	input  logic [31:0]           res_rj_i,
	input  logic [31:0]           res_rd_i,
	input  logic [31:2]           res_pred_npc_i,
	input  logic                  csr_flush_i,
	input  logic [31:0]           csr_target_i,
	output logic                  redirect_o,
	output logic [31:2]           redirect_pc_o,
	output logic [31:0]           link_o
);
	import bpu_pkg::*;

	logic        btb_hit;
	logic [31:2] btb_target;
	br_kind_t    btb_kind;
	logic        bht_taken;
	logic [31:2] ras_top;
	logic        ras_empty;

	logic        flush;
	logic [31:2] flush_pc;
	logic [31:0] link;
	logic        br_taken;
	logic [31:2] br_target;
	br_kind_t    br_kind;
	logic        btb_update;
	logic        bht_update;
	logic        ras_push;
	logic        ras_pop;

	// --------------------------------------------------
	// Prediction tables, read by fetch, trained by resolve
	// --------------------------------------------------
	bpu_btb u_btb (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.rd_pc_i     (fetch_pc_i),
		.hit_o       (btb_hit),
		.rd_target_o (btb_target),
		.rd_kind_o   (btb_kind),
		.wr_en_i     (btb_update),
		.wr_pc_i     (res_pc_i[31:2]),
		.wr_target_i (br_target),
		.wr_kind_i   (br_kind)
	);

	bpu_bht u_bht (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.rd_pc_i     (fetch_pc_i),
		.rd_taken_o  (bht_taken),
		.upd_en_i    (bht_update),
		.upd_pc_i    (res_pc_i[31:2]),
		.upd_taken_i (br_taken)
	);

	bpu_ras u_ras (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (ras_push),
		.push_addr_i (link[31:2]),
		.pop_i       (ras_pop),
		.top_o       (ras_top),
		.empty_o     (ras_empty)
	);

	bpu_predict u_predict (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_stall_i (fetch_stall_i),
		.fetch_pc_i    (fetch_pc_i),
		.btb_hit_i     (btb_hit),
		.btb_target_i  (btb_target),
		.btb_kind_i    (btb_kind),
		.bht_taken_i   (bht_taken),
		.ras_top_i     (ras_top),
		.ras_empty_i   (ras_empty),
		.pred_valid_o  (pred_valid_o),
		.pred_npc_o    (pred_npc_o),
		.pred_taken_o  (pred_taken_o)
	);

	bpf u_bpf (
		.res_valid_i       (res_valid_i),
		.res_stall_i       (res_stall_i),
		.res_pc_i          (res_pc_i),
		.res_inst_i        (res_inst_i),
		.res_branch_type_i (res_branch_type_i),
		.res_cmp_type_i    (res_cmp_type_i),
		.res_link_i        (res_link_i),
		.res_rj_i          (res_rj_i),
		.res_rd_i          (res_rd_i),
		.res_pred_npc_i    (res_pred_npc_i),
		.csr_flush_i       (csr_flush_i),
		.csr_target_i      (csr_target_i),
		.flush_o           (flush),
		.flush_pc_o        (flush_pc),
		.link_o            (link),
		.br_taken_o        (br_taken),
		.br_target_o       (br_target),
		.br_kind_o         (br_kind),
		.btb_update_o      (btb_update),
		.bht_update_o      (bht_update),
		.ras_push_o        (ras_push),
		.ras_pop_o         (ras_pop)
	);

	// Redirect pulse one cycle after resolve
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			redirect_o <= 1'b0;
		end else begin
			redirect_o <= flush;
		end
	end

	always_ff @(posedge clk) begin
		redirect_pc_o <= flush_pc;
		link_o        <= link;
	end

endmodule

// ==== hw/bpf.sv ====
// Branch resolve and feedback: real target, taken, kind, link and mispredict
`timescale 1ns/1ps

module bpf (
	input  logic                  res_valid_i,
	input  logic                  res_stall_i,
	input  logic [31:0]           res_pc_i,
	input  bpu_pkg::branch_inst_u res_inst_i,
	input  bpu_pkg::branch_type_t res_branch_type_i,
	input  bpu_pkg::cmp_type_t    res_cmp_type_i,
	input  logic                  res_link_i,
	input  logic [31:0]           res_rj_i,
	input  logic [31:0]           res_rd_i,
	input  logic [31:2]           res_pred_npc_i,
	input  logic                  csr_flush_i,
	input  logic [31:0]           csr_target_i,
	output logic                  flush_o,
	output logic [31:2]           flush_pc_o,
	output logic [31:0]           link_o,
	output logic                  br_taken_o,
	output logic [31:2]           br_target_o,
	output bpu_pkg::br_kind_t     br_kind_o,
	output logic                  btb_update_o,
	output logic                  bht_update_o,
	output logic                  ras_push_o,
	output logic                  ras_pop_o
);
	import bpu_pkg::*;

	logic [31:0] offs26_sh;
	logic [31:0] offs16_sh;
	logic [31:0] target;
	logic [31:0] real_npc;
	logic        is_branch;
	logic        fire;
	logic        mispredict;

	// Sign extended byte offsets
	assign offs26_sh = {{4{res_inst_i.offs26[25]}}, res_inst_i.offs26, 2'b00};
	assign offs16_sh = {{14{res_inst_i.reg_form.offs16[15]}}, res_inst_i.reg_form.offs16, 2'b00};

	assign link_o = res_pc_i + 32'd4;

	always_comb begin
		case (res_branch_type_i)
			IMMEDIATE: target = res_pc_i + offs26_sh;
			INDIRECT:  target = res_rj_i + offs16_sh;
			CONDITION: target = res_pc_i + offs16_sh;
			default:   target = link_o;
		endcase
	end

	always_comb begin
		if (res_branch_type_i == CONDITION) begin
			case (res_cmp_type_i)
				EQL:     br_taken_o = (res_rj_i == res_rd_i);
				NEQ:     br_taken_o = (res_rj_i != res_rd_i);
				LSS:     br_taken_o = ($signed(res_rj_i) <  $signed(res_rd_i));
				GER:     br_taken_o = ($signed(res_rj_i) >  $signed(res_rd_i));
				LEQ:     br_taken_o = ($signed(res_rj_i) <= $signed(res_rd_i));
				GEQ:     br_taken_o = ($signed(res_rj_i) >= $signed(res_rd_i));
				LTU:     br_taken_o = (res_rj_i <  res_rd_i);
				GEU:     br_taken_o = (res_rj_i >= res_rd_i);
				default: br_taken_o = 1'b0;
			endcase
		end else begin
			br_taken_o = (res_branch_type_i != INVALID);
		end
	end

	// --------------------------------------------------
	// Kind, call takes priority over return
	// --------------------------------------------------
	always_comb begin
		if ((res_branch_type_i == INDIRECT && res_inst_i.reg_form.rd == 5'd1) || res_link_i) begin
			br_kind_o = CALL;
		end else if (res_branch_type_i == INDIRECT && res_inst_i.reg_form.rj == 5'd1 &&
		             res_inst_i.reg_form.offs16 == '0) begin
			br_kind_o = RETURN;
		end else if (res_branch_type_i == IMMEDIATE || res_branch_type_i == INDIRECT) begin
			br_kind_o = ABSOLUTE;
		end else begin
			br_kind_o = PC_RELATIVE;
		end
	end

	assign br_target_o = target[31:2];
	assign real_npc    = br_taken_o ? target : link_o;

	// Stall blocks mispredict and training, a CSR flush still wins
	assign is_branch  = (res_branch_type_i != INVALID);
	assign fire       = res_valid_i && !res_stall_i;
	assign mispredict = fire && (real_npc[31:2] != res_pred_npc_i);

	assign flush_o    = mispredict || csr_flush_i;
	assign flush_pc_o = csr_flush_i ? csr_target_i[31:2] : real_npc[31:2];

	assign btb_update_o = fire && br_taken_o;
	assign bht_update_o = fire && is_branch;
	assign ras_push_o   = fire && is_branch && (br_kind_o == CALL);
	assign ras_pop_o    = fire && is_branch && (br_kind_o == RETURN);

endmodule

// ==== hw/bpu_predict.sv ====
// Next fetch PC selection from BTB, BHT and RAS, registered one cycle later
`timescale 1ns/1ps

module bpu_predict (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              fetch_valid_i,
	input  logic              fetch_stall_i,
	input  logic [31:2]       fetch_pc_i,
	input  logic              btb_hit_i,
	input  logic [31:2]       btb_target_i,
	input  bpu_pkg::br_kind_t btb_kind_i,
	input  logic              bht_taken_i,
	input  logic [31:2]       ras_top_i,
	input  logic              ras_empty_i,
	output logic              pred_valid_o,
	output logic [31:2]       pred_npc_o,
	output logic              pred_taken_o
);
	import bpu_pkg::*;

	logic [31:2] seq_pc;
	logic [31:2] npc_d;
	logic        taken_d;

	assign seq_pc = fetch_pc_i + 30'd1;

	always_comb begin
		npc_d   = seq_pc;
		taken_d = 1'b0;
		if (btb_hit_i && btb_kind_i == RETURN && !ras_empty_i) begin
			npc_d   = ras_top_i;
			taken_d = 1'b1;
		end else if (btb_hit_i &&
		             (btb_kind_i == CALL || btb_kind_i == ABSOLUTE || bht_taken_i)) begin
			npc_d   = btb_target_i;
			taken_d = 1'b1;
		end
	end

	// --------------------------------------------------
	// Prediction register, frozen while fetch stalls
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pred_valid_o <= 1'b0;
			pred_taken_o <= 1'b0;
		end else if (!fetch_stall_i) begin
			pred_valid_o <= fetch_valid_i;
			pred_taken_o <= taken_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!fetch_stall_i) begin
			pred_npc_o <= npc_d;
		end
	end

endmodule

// ==== hw/bpu_ras.sv ====
// Return address stack, circular, push on call and pop on return
`timescale 1ns/1ps

module bpu_ras (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        push_i,
	input  logic [31:2] push_addr_i,
	input  logic        pop_i,
	output logic [31:2] top_o,
	output logic        empty_o
);
	import bpu_pkg::*;

	logic [31:2]          stack_q [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] top_q;
	logic [RAS_PTR_W-1:0] top_inc;
	logic [RAS_PTR_W:0]   count_q;
	logic                 do_push;
	logic                 do_pop;
	logic                 do_replace;

	assign empty_o = (count_q == '0);
	assign top_o   = stack_q[top_q];
	assign top_inc = top_q + 1'b1;

	// Push with pop on a live stack swaps the top in place
	assign do_replace = push_i && pop_i && !empty_o;
	assign do_push    = push_i && !do_replace;
	assign do_pop     = pop_i && !push_i && !empty_o;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			top_q   <= '0;
			count_q <= '0;
		end else if (do_push) begin
			top_q <= top_inc;
			// When full the pointer wraps over the oldest entry
			if (count_q != (RAS_PTR_W+1)'(RAS_DEPTH)) begin
				count_q <= count_q + 1'b1;
			end
		end else if (do_pop) begin
			top_q   <= top_q - 1'b1;
			count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			stack_q[top_inc] <= push_addr_i;
		end else if (do_replace) begin
			stack_q[top_q] <= push_addr_i;
		end
	end

endmodule

// ==== hw/bpu_bht.sv ====
// Branch history table of 2-bit saturating taken counters indexed by PC
`timescale 1ns/1ps

module bpu_bht (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [31:2] rd_pc_i,
	output logic        rd_taken_o,
	input  logic        upd_en_i,
	input  logic [31:2] upd_pc_i,
	input  logic        upd_taken_i
);
	import bpu_pkg::*;

	logic [1:0]           cnt_q [BHT_DEPTH];
	logic [BHT_IDX_W-1:0] rd_idx;
	logic [BHT_IDX_W-1:0] upd_idx;
	logic [1:0]           upd_cnt;

	assign rd_idx  = rd_pc_i[BHT_IDX_W+1:2];
	assign upd_idx = upd_pc_i[BHT_IDX_W+1:2];
	assign upd_cnt = cnt_q[upd_idx];

	// Upper bit means predict taken
	assign rd_taken_o = cnt_q[rd_idx][1];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < BHT_DEPTH; i++) begin
				cnt_q[i] <= BHT_INIT;
			end
		end else if (upd_en_i) begin
			// Saturate at both ends
			if (upd_taken_i && upd_cnt != 2'b11) begin
				cnt_q[upd_idx] <= upd_cnt + 2'd1;
			end else if (!upd_taken_i && upd_cnt != 2'b00) begin
				cnt_q[upd_idx] <= upd_cnt - 2'd1;
			end
		end
	end

endmodule

// ==== hw/bpu_btb.sv ====
// Branch target buffer, direct mapped, holding tag, target and kind per entry
`timescale 1ns/1ps

module bpu_btb (
	input  logic              clk,
	input  logic              rst_n_i,
	// Lookup
	input  logic [31:2]       rd_pc_i,
	output logic              hit_o,
	output logic [31:2]       rd_target_o,
	output bpu_pkg::br_kind_t rd_kind_o,
	// Training
	input  logic              wr_en_i,
	input  logic [31:2]       wr_pc_i,
	input  logic [31:2]       wr_target_i,
	input  bpu_pkg::br_kind_t wr_kind_i
);
	import bpu_pkg::*;

	logic [BTB_DEPTH-1:0] valid_q;
	logic [BTB_TAG_W-1:0] tag_mem [BTB_DEPTH];
	logic [31:2]          target_mem [BTB_DEPTH];
	br_kind_t             kind_mem [BTB_DEPTH];

	logic [BTB_IDX_W-1:0] rd_idx;
	logic [BTB_TAG_W-1:0] rd_tag;
	logic [BTB_IDX_W-1:0] wr_idx;
	logic [BTB_TAG_W-1:0] wr_tag;

	assign rd_idx = rd_pc_i[BTB_IDX_W+1:2];
	assign rd_tag = rd_pc_i[31:BTB_IDX_W+2];
	assign wr_idx = wr_pc_i[BTB_IDX_W+1:2];
	assign wr_tag = wr_pc_i[31:BTB_IDX_W+2];

	// Combinational read
	assign hit_o       = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign rd_target_o = target_mem[rd_idx];
	assign rd_kind_o   = kind_mem[rd_idx];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (wr_en_i) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_mem[wr_idx]    <= wr_tag;
			target_mem[wr_idx] <= wr_target_i;
			kind_mem[wr_idx]   <= wr_kind_i;
		end
	end

endmodule

// ==== hw/bpu_pkg.sv ====
// Branch prediction unit shared sizes, encodings and branch instruction fields
package bpu_pkg;

	// --------------------------------------------------
	// Table sizes
	// --------------------------------------------------
	localparam int BTB_IDX_W  = 4;
	localparam int BTB_DEPTH  = 1 << BTB_IDX_W;
	// Word address is 30 bits, index takes the low part
	localparam int BTB_TAG_W  = 30 - BTB_IDX_W;

	localparam int BHT_IDX_W  = 5;
	localparam int BHT_DEPTH  = 1 << BHT_IDX_W;
	// Weakly not taken
	localparam logic [1:0] BHT_INIT = 2'b01;

	localparam int RAS_DEPTH  = 4;
	localparam int RAS_PTR_W  = $clog2(RAS_DEPTH);

	// --------------------------------------------------
	// Decoder side encodings
	// --------------------------------------------------
	typedef enum logic [1:0] {
		INVALID   = 2'd0,
		IMMEDIATE = 2'd1,
		INDIRECT  = 2'd2,
		CONDITION = 2'd3
	} branch_type_t;

	// Signed compares LSS..GEQ, unsigned LTU/GEU
	typedef enum logic [2:0] {
		EQL = 3'd0,
		NEQ = 3'd1,
		LSS = 3'd2,
		GER = 3'd3,
		LEQ = 3'd4,
		GEQ = 3'd5,
		LTU = 3'd6,
		GEU = 3'd7
	} cmp_type_t;

	// Kind stored per BTB entry
	typedef enum logic [1:0] {
		PC_RELATIVE = 2'd0,
		ABSOLUTE    = 2'd1,
		CALL        = 2'd2,
		RETURN      = 2'd3
	} br_kind_t;

	// Register form of the low 26 instruction bits
	typedef struct packed {
		logic [15:0] offs16;
		logic [4:0]  rj;
		logic [4:0]  rd;
	} branch_reg_form_t;

	// b/bl read offs26, jirl and conditional branches read the register form
	typedef union packed {
		logic [25:0]      offs26;
		branch_reg_form_t reg_form;
	} branch_inst_u;

endpackage
